// ==== hw/dma_defines.svh ====
// Project-wide DMA constants for queue depth and field widths, included by package and RTL
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Transactions held by the shared queue buffer
`define DMA_QUEUE_DEPTH 4

// Slot index and element counter widths for the queue
`define DMA_QUEUE_IDX_WIDTH 2
`define DMA_QUEUE_CNT_WIDTH 3

// Transfer length in words
`define DMA_LEN_WIDTH 16

// Local (TCDM) and external byte addresses
`define DMA_TCDM_ADD_WIDTH 16
`define DMA_EXT_ADD_WIDTH 32

// One register write from the core
`define DMA_REG_WIDTH 32

// Address step of one word beat, in bytes
`define DMA_WORD_BYTES 4

`endif

// ==== hw/dma_pkg.sv ====
// Shared DMA types: field vectors, transaction and beat structs, FSM state encodings
`default_nettype none
`include "dma_defines.svh"

package dma_pkg;

   // Field vectors
   typedef logic [`DMA_LEN_WIDTH-1:0]      len_t;      // Length in words
   typedef logic [`DMA_TCDM_ADD_WIDTH-1:0] tcdm_add_t; // Local byte address
   typedef logic [`DMA_EXT_ADD_WIDTH-1:0]  ext_add_t;  // External byte address
   typedef logic [`DMA_REG_WIDTH-1:0]      reg_data_t; // Register write word

   // One queued transfer, direction bit on top
   typedef struct packed {
      logic      is_rx;    // 0 = tx (local to external), 1 = rx
      len_t      len;
      tcdm_add_t tcdm_add;
      ext_add_t  ext_add;
   } trans_t;

   // Address pair of a single word beat
   typedef struct packed {
      tcdm_add_t tcdm_add;
      ext_add_t  ext_add;
   } beat_t;

   // Command decoder, one state per expected register word
   typedef enum logic [1:0] {
      WAIT_LEN,
      WAIT_TCDM,
      WAIT_EXT,
      PUSH
   } dec_state_e;

   // Channel engine
   typedef enum logic [1:0] {
      IDLE,
      BEATS,
      DONE
   } chan_state_e;

endpackage

`default_nettype wire

// ==== hw/cmd_decoder.sv ====
// Assembles three core register writes into one DMA transaction and hands it to the queue
`timescale 1ns/1ps
`default_nettype none
`include "dma_defines.svh"

module cmd_decoder
(
   input  logic               clk_i,
   input  logic               rst_ni,

   input  logic               reg_wr_i,
   input  dma_pkg::reg_data_t reg_wdata_i,
   output logic               reg_gnt_o,

   output logic               q_req_o,
   output dma_pkg::trans_t    q_dat_o,
   input  logic               q_gnt_i
);

   dma_pkg::dec_state_e s_state;
   dma_pkg::dec_state_e s_state_n;
   dma_pkg::trans_t     r_trans;  // Transaction under assembly
   logic                s_wr;     // Register write accepted this cycle

   // Registers are refused while a finished command waits for the queue
   assign reg_gnt_o = (s_state != dma_pkg::PUSH);
   assign q_req_o   = (s_state == dma_pkg::PUSH);
   assign q_dat_o   = r_trans;

   assign s_wr = reg_wr_i && reg_gnt_o;

   always_comb
   begin
      s_state_n = s_state;
      case (s_state)
         dma_pkg::WAIT_LEN:  if (s_wr) s_state_n = dma_pkg::WAIT_TCDM;
         dma_pkg::WAIT_TCDM: if (s_wr) s_state_n = dma_pkg::WAIT_EXT;
         dma_pkg::WAIT_EXT:  if (s_wr) s_state_n = dma_pkg::PUSH;
         dma_pkg::PUSH:      if (q_gnt_i) s_state_n = dma_pkg::WAIT_LEN;
         default:            s_state_n = dma_pkg::WAIT_LEN;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         s_state <= dma_pkg::WAIT_LEN;
      else
         s_state <= s_state_n;
   end

   // Field capture, one field group per command word
   always_ff @(posedge clk_i)
   begin
      if (s_wr)
      begin
         case (s_state)
            dma_pkg::WAIT_LEN:
            begin
               r_trans.len   <= reg_wdata_i[`DMA_LEN_WIDTH-1:0];
               r_trans.is_rx <= reg_wdata_i[`DMA_LEN_WIDTH];  // Direction flag above length
            end
            dma_pkg::WAIT_TCDM: r_trans.tcdm_add <= reg_wdata_i[`DMA_TCDM_ADD_WIDTH-1:0];
            dma_pkg::WAIT_EXT:  r_trans.ext_add  <= reg_wdata_i[`DMA_EXT_ADD_WIDTH-1:0];
            default:            r_trans <= r_trans;
         endcase
      end
   end

   // A zero-length command would leave a channel with nothing to send
   a_len_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(q_req_o) |-> (q_dat_o.len != '0))
      else $error("cmd_decoder: zero-length command offered to the queue");

endmodule

`default_nettype wire

// ==== hw/trans_queue.sv ====
// Shared-buffer transaction queue with independent in-order tx and rx outputs
`timescale 1ns/1ps
`default_nettype none
`include "dma_defines.svh"

module trans_queue
(
   input  logic            clk_i,
   input  logic            rst_ni,

   input  logic            req_i,
   output logic            gnt_o,
   input  dma_pkg::trans_t dat_i,

   output logic            tx_req_o,
   input  logic            tx_gnt_i,
   output dma_pkg::trans_t tx_dat_o,

   output logic            rx_req_o,
   input  logic            rx_gnt_i,
   output dma_pkg::trans_t rx_dat_o
);

   typedef logic [`DMA_QUEUE_IDX_WIDTH-1:0] idx_t;
   typedef logic [`DMA_QUEUE_CNT_WIDTH-1:0] cnt_t;

   // Payload storage, any slot may hold either direction
   dma_pkg::trans_t s_buffer [`DMA_QUEUE_DEPTH];

   // Per-direction tables of buffer slots in arrival order
   idx_t s_tx_table [`DMA_QUEUE_DEPTH];
   idx_t s_rx_table [`DMA_QUEUE_DEPTH];

   idx_t s_tx_wr;   // Next tx table entry to fill
   idx_t s_tx_rd;   // Oldest tx table entry
   idx_t s_rx_wr;
   idx_t s_rx_rd;

   logic [`DMA_QUEUE_DEPTH-1:0] s_busy;  // Slot holds a live transaction
   idx_t s_free_idx;                     // Lowest free slot

   cnt_t s_elements;
   cnt_t s_tx_elements;
   cnt_t s_rx_elements;

   logic s_full;
   logic s_push;
   logic s_push_tx;
   logic s_push_rx;
   logic s_pop_tx;
   logic s_pop_rx;

   assign s_full   = (s_elements == cnt_t'(`DMA_QUEUE_DEPTH));
   assign gnt_o    = !s_full;
   assign s_push   = req_i && !s_full;

   assign s_push_tx = s_push && !dat_i.is_rx;
   assign s_push_rx = s_push && dat_i.is_rx;
   assign s_pop_tx  = tx_req_o && tx_gnt_i;
   assign s_pop_rx  = rx_req_o && rx_gnt_i;

   // Priority search for the lowest slot not in use
   always_comb
   begin
      s_free_idx = '0;
      for (int i = `DMA_QUEUE_DEPTH - 1; i >= 0; i--)
      begin
         if (!s_busy[i])
            s_free_idx = idx_t'(i);
      end
   end

   // Element counters, push and both pops may coincide
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         s_elements    <= '0;
         s_tx_elements <= '0;
         s_rx_elements <= '0;
      end
      else
      begin
         s_elements    <= s_elements + cnt_t'(s_push) - cnt_t'(s_pop_tx) - cnt_t'(s_pop_rx);
         s_tx_elements <= s_tx_elements + cnt_t'(s_push_tx) - cnt_t'(s_pop_tx);
         s_rx_elements <= s_rx_elements + cnt_t'(s_push_rx) - cnt_t'(s_pop_rx);
      end
   end

   // Busy tags and table pointers, which wrap with the power-of-two depth
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         s_busy  <= '0;
         s_tx_wr <= '0;
         s_tx_rd <= '0;
         s_rx_wr <= '0;
         s_rx_rd <= '0;
      end
      else
      begin
         if (s_push)
            s_busy[s_free_idx] <= 1'b1;
         if (s_push_tx)
            s_tx_wr <= s_tx_wr + 1'b1;
         if (s_push_rx)
            s_rx_wr <= s_rx_wr + 1'b1;

         if (s_pop_tx)
         begin
            s_busy[s_tx_table[s_tx_rd]] <= 1'b0;  // Release slot of oldest tx
            s_tx_rd <= s_tx_rd + 1'b1;
         end
         if (s_pop_rx)
         begin
            s_busy[s_rx_table[s_rx_rd]] <= 1'b0;
            s_rx_rd <= s_rx_rd + 1'b1;
         end
      end
   end

   // Payload and slot tables
   always_ff @(posedge clk_i)
   begin
      if (s_push)
         s_buffer[s_free_idx] <= dat_i;
      if (s_push_tx)
         s_tx_table[s_tx_wr] <= s_free_idx;
      if (s_push_rx)
         s_rx_table[s_rx_wr] <= s_free_idx;
   end

   assign tx_dat_o = s_buffer[s_tx_table[s_tx_rd]];
   assign rx_dat_o = s_buffer[s_rx_table[s_rx_rd]];

   assign tx_req_o = (s_tx_elements != '0);
   assign rx_req_o = (s_rx_elements != '0);

   // Direction counts and busy tags both account for every stored element
   a_count_sum: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (s_elements == s_tx_elements + s_rx_elements) &&
      (s_elements == cnt_t'($countones(s_busy))))
      else $error("trans_queue: element counts disagree with each other or the busy tags");

   // Busy tags must agree with the full flag
   a_push_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
      s_push |-> !s_busy[s_free_idx])
      else $error("trans_queue: push into a busy slot");

endmodule

`default_nettype wire

// ==== hw/xfer_channel.sv ====
// Channel engine that turns one queued transaction into a stream of single-word beats
`timescale 1ns/1ps
`default_nettype none
`include "dma_defines.svh"

module xfer_channel
(
   input  logic            clk_i,
   input  logic            rst_ni,

   input  logic            trans_req_i,
   output logic            trans_gnt_o,
   input  dma_pkg::trans_t trans_i,

   output logic            beat_valid_o,
   output dma_pkg::beat_t  beat_o,
   input  logic            beat_gnt_i,

   output logic            done_o
);

   dma_pkg::chan_state_e s_state;
   dma_pkg::chan_state_e s_state_n;
   dma_pkg::len_t        r_len;   // Words still to send
   dma_pkg::beat_t       r_beat;  // Current address pair
   logic                 s_beat_acc;

   assign trans_gnt_o  = (s_state == dma_pkg::IDLE) && trans_req_i;
   assign beat_valid_o = (s_state == dma_pkg::BEATS);
   assign done_o       = (s_state == dma_pkg::DONE);
   assign beat_o       = r_beat;

   assign s_beat_acc = beat_valid_o && beat_gnt_i;

   always_comb
   begin
      s_state_n = s_state;
      case (s_state)
         dma_pkg::IDLE:
         begin
            // Empty command skips straight to completion
            if (trans_req_i)
               s_state_n = (trans_i.len == '0) ? dma_pkg::DONE : dma_pkg::BEATS;
         end
         dma_pkg::BEATS:
         begin
            if (s_beat_acc && (r_len == dma_pkg::len_t'(1)))
               s_state_n = dma_pkg::DONE;
         end
         dma_pkg::DONE: s_state_n = dma_pkg::IDLE;
         default:       s_state_n = dma_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         s_state <= dma_pkg::IDLE;
      else
         s_state <= s_state_n;
   end

   // Latch on grant, then step one word per accepted beat
   always_ff @(posedge clk_i)
   begin
      if (trans_gnt_o)
      begin
         r_len           <= trans_i.len;
         r_beat.tcdm_add <= trans_i.tcdm_add;
         r_beat.ext_add  <= trans_i.ext_add;
      end
      else if (s_beat_acc)
      begin
         r_len           <= r_len - dma_pkg::len_t'(1);
         r_beat.tcdm_add <= r_beat.tcdm_add + dma_pkg::tcdm_add_t'(`DMA_WORD_BYTES);
         r_beat.ext_add  <= r_beat.ext_add + dma_pkg::ext_add_t'(`DMA_WORD_BYTES);
      end
   end

   // Stalled beat keeps its request and address pair
   a_beat_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (beat_valid_o && !beat_gnt_i) |=> (beat_valid_o && $stable(beat_o)))
      else $error("xfer_channel: beat changed while waiting for grant");

endmodule

`default_nettype wire

// ==== hw/dma_trans_top.sv ====
// DMA command front end: decoder, shared transaction queue and the tx and rx channel engines
`timescale 1ns/1ps
`default_nettype none

module dma_trans_top
(
   input  logic               clk_i,
   input  logic               rst_ni,

   input  logic               reg_wr_i,
   input  dma_pkg::reg_data_t reg_wdata_i,
   output logic               reg_gnt_o,

   output logic               tx_beat_valid_o,
   output dma_pkg::beat_t     tx_beat_o,
   input  logic               tx_beat_gnt_i,
   output logic               tx_done_o,

   output logic               rx_beat_valid_o,
   output dma_pkg::beat_t     rx_beat_o,
   input  logic               rx_beat_gnt_i,
   output logic               rx_done_o
);

   // Decoder to queue
   logic            s_q_req;
   logic            s_q_gnt;
   dma_pkg::trans_t s_q_dat;

   // Queue to channels
   logic            s_tx_req;
   logic            s_tx_gnt;
   dma_pkg::trans_t s_tx_dat;
   logic            s_rx_req;
   logic            s_rx_gnt;
   dma_pkg::trans_t s_rx_dat;

   cmd_decoder u_decoder
   (
      .clk_i       ( clk_i       ),
      .rst_ni      ( rst_ni      ),
      .reg_wr_i    ( reg_wr_i    ),
      .reg_wdata_i ( reg_wdata_i ),
      .reg_gnt_o   ( reg_gnt_o   ),
      .q_req_o     ( s_q_req     ),
      .q_dat_o     ( s_q_dat     ),
      .q_gnt_i     ( s_q_gnt     )
   );

   trans_queue u_queue
   (
      .clk_i    ( clk_i    ),
      .rst_ni   ( rst_ni   ),
      .req_i    ( s_q_req  ),
      .gnt_o    ( s_q_gnt  ),
      .dat_i    ( s_q_dat  ),
      .tx_req_o ( s_tx_req ),
      .tx_gnt_i ( s_tx_gnt ),
      .tx_dat_o ( s_tx_dat ),
      .rx_req_o ( s_rx_req ),
      .rx_gnt_i ( s_rx_gnt ),
      .rx_dat_o ( s_rx_dat )
   );

   xfer_channel u_tx_chan  // Local to external
   (
      .clk_i        ( clk_i           ),
      .rst_ni       ( rst_ni          ),
      .trans_req_i  ( s_tx_req        ),
      .trans_gnt_o  ( s_tx_gnt        ),
      .trans_i      ( s_tx_dat        ),
      .beat_valid_o ( tx_beat_valid_o ),
      .beat_o       ( tx_beat_o       ),
      .beat_gnt_i   ( tx_beat_gnt_i   ),
      .done_o       ( tx_done_o       )
   );

   xfer_channel u_rx_chan  // External to local
   (
      .clk_i        ( clk_i           ),
      .rst_ni       ( rst_ni          ),
      .trans_req_i  ( s_rx_req        ),
      .trans_gnt_o  ( s_rx_gnt        ),
      .trans_i      ( s_rx_dat        ),
      .beat_valid_o ( rx_beat_valid_o ),
      .beat_o       ( rx_beat_o       ),
      .beat_gnt_i   ( rx_beat_gnt_i   ),
      .done_o       ( rx_done_o       )
   );

endmodule

`default_nettype wire

// ==== bench/tb_dma_trans.sv ====
// Directed testbench for the DMA command front end, models both beat streams and checks them
`timescale 1ns/1ps
`default_nettype none
`include "dma_defines.svh"

module tb_dma_trans;

   localparam int NUM_CMDS        = 36;   // Commands over all tests
   localparam int MAX_WORDS       = 200;  // Upper bound of words over all tests
   localparam int WATCHDOG_CYCLES = 200 * NUM_CMDS + 4 * MAX_WORDS;

   logic               clk_i;
   logic               rst_ni;
   logic               reg_wr_i;
   dma_pkg::reg_data_t reg_wdata_i;
   logic               reg_gnt_o;
   logic               tx_beat_valid_o;
   dma_pkg::beat_t     tx_beat_o;
   logic               tx_beat_gnt_i;
   logic               tx_done_o;
   logic               rx_beat_valid_o;
   dma_pkg::beat_t     rx_beat_o;
   logic               rx_beat_gnt_i;
   logic               rx_done_o;

   string          cur_test;
   bit             rand_gnt;      // Random beat grants instead of fixed levels
   bit             tx_gnt_level;
   bit             rx_gnt_level;
   dma_pkg::beat_t exp_tx[$];     // Expected beats per direction, oldest first
   dma_pkg::beat_t exp_rx[$];
   int             len_tx[$];     // Expected length of each pending command
   int             len_rx[$];
   int             cmd_cnt[2];    // Index 0 is tx, 1 is rx
   int             done_cnt[2];
   int             run_beats[2];  // Beats since the last done pulse

   dma_trans_top uut
   (
      .clk_i           ( clk_i           ),
      .rst_ni          ( rst_ni          ),
      .reg_wr_i        ( reg_wr_i        ),
      .reg_wdata_i     ( reg_wdata_i     ),
      .reg_gnt_o       ( reg_gnt_o       ),
      .tx_beat_valid_o ( tx_beat_valid_o ),
      .tx_beat_o       ( tx_beat_o       ),
      .tx_beat_gnt_i   ( tx_beat_gnt_i   ),
      .tx_done_o       ( tx_done_o       ),
      .rx_beat_valid_o ( rx_beat_valid_o ),
      .rx_beat_o       ( rx_beat_o       ),
      .rx_beat_gnt_i   ( rx_beat_gnt_i   ),
      .rx_done_o       ( rx_done_o       )
   );

   always #10 clk_i = ~clk_i;  // 20 ns period

   always @(posedge clk_i)
   begin
      if (rand_gnt)
      begin
         tx_beat_gnt_i <= ($urandom % 4) != 0;
         rx_beat_gnt_i <= ($urandom % 3) != 0;
      end
      else
      begin
         tx_beat_gnt_i <= tx_gnt_level;
         rx_beat_gnt_i <= rx_gnt_level;
      end
   end

   task automatic abort_run(input string why);
      $display("%s: %s", cur_test, why);
      $display("Simulation failed");
      $fatal(1, "run aborted");
   endtask

   task automatic compare_value(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
      if (exp !== act)
      begin
         $display("CHECK FAILED %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic take_beat(input bit is_rx, input dma_pkg::beat_t act);
      dma_pkg::beat_t exp;
      if ((is_rx && exp_rx.size() == 0) || (!is_rx && exp_tx.size() == 0))
         abort_run(is_rx ? "rx beat with no command pending" : "tx beat with no command pending");
      else
      begin
         if (is_rx)
            exp = exp_rx.pop_front();
         else
            exp = exp_tx.pop_front();
         compare_value(is_rx ? "rx beat" : "tx beat", 64'(exp), 64'(act));
         run_beats[is_rx]++;
      end
   endtask

   task automatic take_done(input bit is_rx);
      int exp_len;
      if ((is_rx && len_rx.size() == 0) || (!is_rx && len_tx.size() == 0))
         abort_run(is_rx ? "rx done pulse without a command" : "tx done pulse without a command");
      else
      begin
         if (is_rx)
            exp_len = len_rx.pop_front();
         else
            exp_len = len_tx.pop_front();
         compare_value(is_rx ? "rx beats per command" : "tx beats per command",
                       64'(exp_len), 64'(run_beats[is_rx]));
         run_beats[is_rx] = 0;
         done_cnt[is_rx]++;
      end
   endtask

   // Outputs are stable at the falling edge, a granted beat is taken at the next rising edge
   always @(negedge clk_i)
   begin
      if (rst_ni)
      begin
         if (tx_beat_valid_o && tx_beat_gnt_i)
            take_beat(1'b0, tx_beat_o);
         if (rx_beat_valid_o && rx_beat_gnt_i)
            take_beat(1'b1, rx_beat_o);
         if (tx_done_o)
            take_done(1'b0);
         if (rx_done_o)
            take_done(1'b1);
      end
   end

   // Request held until the grant is seen
   task automatic write_word(input dma_pkg::reg_data_t word);
      @(posedge clk_i);
      reg_wr_i    <= 1'b1;
      reg_wdata_i <= word;
      do
         @(negedge clk_i);
      while (!reg_gnt_o);
   endtask

   task automatic write_cmd(input bit is_rx, input int len, input dma_pkg::tcdm_add_t tcdm,
                            input dma_pkg::ext_add_t ext);
      dma_pkg::beat_t b;
      for (int i = 0; i < len; i++)
      begin
         b.tcdm_add = tcdm + dma_pkg::tcdm_add_t'(4 * i);  // One word per beat
         b.ext_add  = ext + dma_pkg::ext_add_t'(4 * i);
         if (is_rx)
            exp_rx.push_back(b);
         else
            exp_tx.push_back(b);
      end
      if (is_rx)
         len_rx.push_back(len);
      else
         len_tx.push_back(len);
      cmd_cnt[is_rx]++;
      write_word({15'b0, is_rx, dma_pkg::len_t'(len)});
      write_word({16'b0, tcdm});
      write_word(ext);
      @(posedge clk_i);
      reg_wr_i <= 1'b0;
   endtask

   task automatic wait_drained();
      while (exp_tx.size() != 0 || exp_rx.size() != 0 ||
             done_cnt[0] != cmd_cnt[0] || done_cnt[1] != cmd_cnt[1])
         @(negedge clk_i);
      @(negedge clk_i);
   endtask

   // The idle direction gets no grant, so a stray beat would stay visible
   task automatic single_tx_test();
      cur_test     = "single_tx";
      tx_gnt_level = 1'b1;
      rx_gnt_level = 1'b0;
      write_cmd(1'b0, 3, 16'h0100, 32'h8000_0000);
      wait_drained();
      compare_value("rx beat valid", 0, 64'(rx_beat_valid_o));
   endtask

   task automatic single_rx_test();
      cur_test     = "single_rx";
      tx_gnt_level = 1'b0;
      rx_gnt_level = 1'b1;
      write_cmd(1'b1, 3, 16'h0200, 32'h8000_1000);
      wait_drained();
      compare_value("tx beat valid", 0, 64'(tx_beat_valid_o));
   endtask

   task automatic alternating_order_test();
      cur_test     = "alternating_order";
      tx_gnt_level = 1'b1;
      rx_gnt_level = 1'b0;  // rx stalls, tx must keep moving
      for (int n = 0; n < 6; n++)
         write_cmd(n % 2 == 1, 2 + n % 3, 16'h1000 + 16'(n * 32), 32'h4000_0000 + 32'(n * 128));
      while (done_cnt[0] != cmd_cnt[0] || exp_tx.size() != 0)
         @(negedge clk_i);
      compare_value("rx beat valid while stalled", 1, 64'(rx_beat_valid_o));
      compare_value("rx beat while stalled", 64'(exp_rx[0]), 64'(rx_beat_o));
      rx_gnt_level = 1'b1;
      wait_drained();
   endtask

   task automatic backpressure_test();
      cur_test     = "backpressure";
      tx_gnt_level = 1'b0;
      rx_gnt_level = 1'b0;
      // Two channels, the full queue and the decoder each hold one command
      for (int n = 0; n < `DMA_QUEUE_DEPTH + 3; n++)
         write_cmd(n % 2 == 1, 2, 16'h4000 + 16'(n * 64), 32'h9000_0000 + 32'(n * 256));
      repeat (20)
      begin
         @(negedge clk_i);
         compare_value("reg_gnt_o while full", 0, 64'(reg_gnt_o));
      end
      tx_gnt_level = 1'b1;
      rx_gnt_level = 1'b1;
      write_cmd(1'b1, 2, 16'h7000, 32'h9000_8000);
      wait_drained();
   endtask

   task automatic random_mix_test();
      bit                 is_rx;
      int                 len;
      dma_pkg::tcdm_add_t tcdm;
      dma_pkg::ext_add_t  ext;
      cur_test = "random_mix";
      rand_gnt = 1'b1;
      for (int n = 0; n < 20; n++)
      begin
         is_rx = 1'($urandom % 2);
         len   = 1 + int'($urandom % 8);
         tcdm  = dma_pkg::tcdm_add_t'($urandom) & 16'hfffc;  // Word aligned
         ext   = $urandom & 32'hffff_fffc;
         write_cmd(is_rx, len, tcdm, ext);
      end
      wait_drained();
      rand_gnt = 1'b0;
   endtask

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      abort_run("watchdog expired before the tests finished");
   end

   initial
   begin
      void'($urandom(32'he42a_3011));
      clk_i         = 1'b0;
      rst_ni        = 1'b0;
      reg_wr_i      = 1'b0;
      reg_wdata_i   = '0;
      tx_beat_gnt_i = 1'b0;
      rx_beat_gnt_i = 1'b0;
      rand_gnt      = 1'b0;
      tx_gnt_level  = 1'b0;
      rx_gnt_level  = 1'b0;
      cur_test      = "reset";
      repeat (5) @(posedge clk_i);
      compare_value("reg_gnt_o in reset", 1, 64'(reg_gnt_o));
      compare_value("beat valids in reset", 0, 64'({tx_beat_valid_o, rx_beat_valid_o}));
      compare_value("done pulses in reset", 0, 64'({tx_done_o, rx_done_o}));
      rst_ni <= 1'b1;

      single_tx_test();
      single_rx_test();
      alternating_order_test();
      backpressure_test();
      random_mix_test();

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hw
hw/dma_pkg.sv
hw/cmd_decoder.sv
hw/trans_queue.sv
hw/xfer_channel.sv
hw/dma_trans_top.sv
bench/tb_dma_trans.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log for a failure report
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dma_trans -Mdir obj_dir -f files.f

# A failing run exits non-zero, so the log search decides the result
./obj_dir/Vtb_dma_trans > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
   echo "run.sh: failure reported in sim.log"
   exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
   echo "run.sh: simulation ended without a result"
   exit 1
fi
echo "run.sh: no failure found in sim.log"
